// ==== hw/bus_pkg.sv ====
package bus_pkg;

  // **************************************************
  // processor memory port widths
  // **************************************************

  localparam int addr_width = 32;
  localparam int data_width = 32;
  localparam int strb_width = data_width / 8;

  // byte address as issued by the core
  typedef logic [addr_width-1:0] addr_t;

  typedef logic [data_width-1:0] data_t;

  // one enable per byte lane, all zero means the request is a read
  typedef logic [strb_width-1:0] strb_t;

  // **************************************************
  // request and response of one port
  // **************************************************

  // valid and every other field stay steady until ready comes back
  typedef struct packed {
    logic  valid;
    logic  instr;
    addr_t addr;
    data_t wdata;
    strb_t wstrb;
  } mem_req_t;

  // ready lasts one cycle, rdata only means something on a read
  typedef struct packed {
    logic  ready;
    data_t rdata;
  } mem_rsp_t;

endpackage

// ==== hw/axi_pkg.sv ====
package axi_pkg;

  // **************************************************
  // AXI4 field widths
  // **************************************************

  localparam int addr_width = 32;
  localparam int data_width = 32;
  localparam int strb_width = data_width / 8;

  typedef logic [addr_width-1:0] axi_addr_t;
  typedef logic [data_width-1:0] axi_data_t;
  typedef logic [strb_width-1:0] axi_strb_t;

  typedef logic [7:0] len_t;
  typedef logic [2:0] size_t;
  typedef logic [1:0] burst_t;
  typedef logic [3:0] cache_t;
  typedef logic [3:0] qos_t;

  // bit 2 set marks an instruction fetch
  typedef logic [2:0] prot_t;

  typedef logic [1:0] resp_t;

  localparam resp_t  resp_okay   = 2'b00;
  localparam size_t  size_word   = 3'b010;
  localparam burst_t burst_fixed = 2'b00;

  // **************************************************
  // channel payloads
  // **************************************************

  // read and write address channels carry the same fields
  typedef struct packed {
    axi_addr_t addr;
    len_t      len;
    size_t     size;
    burst_t    burst;
    logic      lock;
    cache_t    cache;
    prot_t     prot;
    qos_t      qos;
    logic      valid;
  } axi_ax_t;

  typedef axi_ax_t axi_aw_t;
  typedef axi_ax_t axi_ar_t;

  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
    logic      last;
    logic      valid;
  } axi_w_t;

  typedef struct packed {
    resp_t resp;
    logic  valid;
  } axi_b_t;

  typedef struct packed {
    axi_data_t data;
    resp_t     resp;
    logic      last;
    logic      valid;
  } axi_r_t;

  // handshake signals that flow against their channel
  typedef struct packed {
    logic bready;
    logic rready;
  } axi_master_ready_t;

  typedef struct packed {
    logic awready;
    logic wready;
    logic arready;
  } axi_slave_ready_t;

endpackage

// ==== hw/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
  input  logic              clk,
  input  logic              rst,
  input  bus_pkg::mem_req_t instr_req,
  input  bus_pkg::mem_req_t data_req,
  input  bus_pkg::mem_rsp_t bus_rsp,
  output bus_pkg::mem_rsp_t instr_rsp,
  output bus_pkg::mem_rsp_t data_rsp,
  output bus_pkg::mem_req_t bus_req
);

  // a transaction is in flight on the bridge
  logic held_q;
  logic owner_data_q;
  // set when the data port wins a tie
  logic prio_data_q;

  logic pick_data;
  logic gnt_instr;
  logic gnt_data;

  // **************************************************
  // grant selection
  // **************************************************

  // a fresh grant is decided in the same cycle so the bridge loses no time
  always_comb begin
    pick_data = data_req.valid && (prio_data_q || !instr_req.valid);
    if (held_q) begin
      gnt_data  = owner_data_q;
      gnt_instr = !owner_data_q;
    end else begin
      gnt_data  = pick_data;
      gnt_instr = instr_req.valid && !pick_data;
    end
  end

  always_comb begin
    bus_req   = '0;
    instr_rsp = '0;
    data_rsp  = '0;
    if (gnt_data) begin
      bus_req  = data_req;
      data_rsp = bus_rsp;
    end else if (gnt_instr) begin
      bus_req   = instr_req;
      instr_rsp = bus_rsp;
    end
  end

  // **************************************************
  // grant state
  // **************************************************

  always_ff @(posedge clk) begin
    if (!rst) begin
      held_q       <= 1'b0;
      owner_data_q <= 1'b0;
      prio_data_q  <= 1'b1;
    end else if (held_q) begin
      if (bus_rsp.ready) begin
        held_q <= 1'b0;
        // the port just served goes to the back of the line
        prio_data_q <= !owner_data_q;
      end
    end else if (gnt_instr || gnt_data) begin
      held_q       <= 1'b1;
      owner_data_q <= gnt_data;
    end
  end

  one_grant: assert property (@(posedge clk) disable iff (!rst)
    !(gnt_instr && gnt_data));

  // the port keeps the bridge until the bridge reports completion
  grant_stable: assert property (@(posedge clk) disable iff (!rst)
    (gnt_instr || gnt_data) && !bus_rsp.ready |=> $stable({gnt_instr, gnt_data}));

endmodule

// ==== hw/axi_master.sv ====
`timescale 1ns/1ps

module axi_master (
  input  logic                       clk,
  input  logic                       rst,
  input  bus_pkg::mem_req_t          req,
  input  axi_pkg::axi_b_t            b,
  input  axi_pkg::axi_r_t            r,
  input  axi_pkg::axi_slave_ready_t  s_ready,
  output bus_pkg::mem_rsp_t          rsp,
  output axi_pkg::axi_aw_t           aw,
  output axi_pkg::axi_w_t            w,
  output axi_pkg::axi_ar_t           ar,
  output axi_pkg::axi_master_ready_t m_ready
);

  typedef enum logic [1:0] {
    st_idle,
    st_read,
    st_write
  } state_e;

  state_e state_q;
  state_e state_d;

  logic awvalid_q;
  logic wvalid_q;
  logic arvalid_q;

  bus_pkg::addr_t addr_q;
  bus_pkg::data_t wdata_q;
  bus_pkg::strb_t wstrb_q;
  axi_pkg::prot_t prot_q;

  bus_pkg::addr_t addr;
  bus_pkg::data_t wdata;
  bus_pkg::strb_t wstrb;
  axi_pkg::prot_t prot;
  logic           aw_valid;
  logic           w_valid;
  logic           ar_valid;

  logic is_write;
  logic write_done;
  logic read_done;

  // single beat of one word, no lock, cache or QoS hints
  function automatic axi_pkg::axi_ax_t single_beat(input bus_pkg::addr_t a,
                                                   input axi_pkg::prot_t p,
                                                   input logic v);
    axi_pkg::axi_ax_t ax;
    ax       = '0;
    ax.addr  = a;
    ax.len   = '0;
    ax.size  = axi_pkg::size_word;
    ax.burst = axi_pkg::burst_fixed;
    ax.lock  = 1'b0;
    ax.cache = '0;
    ax.prot  = p;
    ax.qos   = '0;
    ax.valid = v;
    return ax;
  endfunction

  assign is_write = |req.wstrb;

  // **************************************************
  // channel drive
  // **************************************************

  // in idle the request goes straight out, afterwards the latched copy holds it
  always_comb begin
    if (state_q == st_idle) begin
      addr     = req.addr;
      wdata    = req.wdata;
      wstrb    = req.wstrb;
      prot     = {req.instr, 2'b00};
      aw_valid = req.valid && is_write;
      w_valid  = req.valid && is_write;
      ar_valid = req.valid && !is_write;
    end else begin
      addr     = addr_q;
      wdata    = wdata_q;
      wstrb    = wstrb_q;
      prot     = prot_q;
      aw_valid = awvalid_q;
      w_valid  = wvalid_q;
      ar_valid = arvalid_q;
    end
  end

  assign aw = single_beat(addr, prot, aw_valid);
  assign ar = single_beat(addr, prot, ar_valid);

  assign w.data  = wdata;
  assign w.strb  = wstrb;
  assign w.last  = 1'b1;
  assign w.valid = w_valid;

  assign m_ready.bready = (state_q == st_write);
  assign m_ready.rready = (state_q == st_read);

  assign write_done = (state_q == st_write) && b.valid && (b.resp == axi_pkg::resp_okay);
  assign read_done  = (state_q == st_read) && r.valid && r.last &&
                      (r.resp == axi_pkg::resp_okay);

  assign rsp.ready = write_done || read_done;
  assign rsp.rdata = read_done ? r.data : '0;

  // **************************************************
  // state
  // **************************************************

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (req.valid) begin
          state_d = is_write ? st_write : st_read;
        end
      end
      st_read: begin
        if (read_done) begin
          state_d = st_idle;
        end
      end
      st_write: begin
        if (write_done) begin
          state_d = st_idle;
        end
      end
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      state_q   <= st_idle;
      awvalid_q <= 1'b0;
      wvalid_q  <= 1'b0;
      arvalid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // each valid falls the cycle after its ready is seen
      awvalid_q <= aw_valid && !s_ready.awready;
      wvalid_q  <= w_valid && !s_ready.wready;
      arvalid_q <= ar_valid && !s_ready.arready;
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == st_idle) begin
      addr_q  <= addr;
      wdata_q <= wdata;
      wstrb_q <= wstrb;
      prot_q  <= prot;
    end
  end

  aw_steady: assert property (@(posedge clk) disable iff (!rst)
    aw.valid && !s_ready.awready |=> aw.valid && $stable(aw.addr));

  ar_steady: assert property (@(posedge clk) disable iff (!rst)
    ar.valid && !s_ready.arready |=> ar.valid && $stable(ar.addr));

  one_address: assert property (@(posedge clk) disable iff (!rst)
    !(aw.valid && ar.valid));

endmodule

// ==== hw/axi_sram.sv ====
`timescale 1ns/1ps

module axi_sram #(
  parameter int DEPTH = 256
) (
  input  logic                       clk,
  input  logic                       rst,
  input  axi_pkg::axi_aw_t           aw,
  input  axi_pkg::axi_w_t            w,
  input  axi_pkg::axi_ar_t           ar,
  input  axi_pkg::axi_master_ready_t m_ready,
  output axi_pkg::axi_b_t            b,
  output axi_pkg::axi_r_t            r,
  output axi_pkg::axi_slave_ready_t  s_ready
);

  localparam int idx_width = $clog2(DEPTH);

  typedef logic [idx_width-1:0] idx_t;

  // one transaction at a time, a pending write wins over a read
  typedef enum logic [2:0] {
    st_idle,
    st_wr_accept,
    st_wr_resp,
    st_rd_accept,
    st_rd_resp
  } state_e;

  state_e state_q;
  state_e state_d;

  axi_pkg::axi_data_t mem [DEPTH];
  axi_pkg::axi_data_t rdata_q;

  idx_t wr_idx;
  idx_t rd_idx;

  // word address wraps inside the array
  function automatic idx_t word_index(input axi_pkg::axi_addr_t a);
    return idx_t'((a >> 2) % DEPTH);
  endfunction

  assign wr_idx = word_index(aw.addr);
  assign rd_idx = word_index(ar.addr);

  // **************************************************
  // handshake FSM
  // **************************************************

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (aw.valid && w.valid) begin
          state_d = st_wr_accept;
        end else if (ar.valid) begin
          state_d = st_rd_accept;
        end
      end
      st_wr_accept: state_d = st_wr_resp;
      st_wr_resp: begin
        if (m_ready.bready) begin
          state_d = st_idle;
        end
      end
      st_rd_accept: state_d = st_rd_resp;
      st_rd_resp: begin
        if (m_ready.rready) begin
          state_d = st_idle;
        end
      end
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  assign s_ready.awready = (state_q == st_wr_accept);
  assign s_ready.wready  = (state_q == st_wr_accept);
  assign s_ready.arready = (state_q == st_rd_accept);

  assign b.valid = (state_q == st_wr_resp);
  assign b.resp  = axi_pkg::resp_okay;

  assign r.valid = (state_q == st_rd_resp);
  assign r.data  = rdata_q;
  assign r.resp  = axi_pkg::resp_okay;
  assign r.last  = 1'b1;

  // **************************************************
  // storage
  // **************************************************

  // address and data are still held by the master during the accept cycle
  always_ff @(posedge clk) begin
    if (state_q == st_wr_accept) begin
      for (int i = 0; i < $bits(axi_pkg::axi_strb_t); i++) begin
        if (w.strb[i]) begin
          mem[wr_idx][8*i +: 8] <= w.data[8*i +: 8];
        end
      end
    end
    if (state_q == st_rd_accept) begin
      rdata_q <= mem[rd_idx];
    end
  end

  one_response: assert property (@(posedge clk) disable iff (!rst)
    !(b.valid && r.valid));

  b_held: assert property (@(posedge clk) disable iff (!rst)
    b.valid && !m_ready.bready |=> b.valid);

  r_held: assert property (@(posedge clk) disable iff (!rst)
    r.valid && !m_ready.rready |=> r.valid && $stable(r.data));

endmodule

// ==== hw/mem_subsystem.sv ====
`timescale 1ns/1ps

module mem_subsystem #(
  parameter int DEPTH = 256
) (
  input  logic              clk,
  input  logic              rst,
  input  bus_pkg::mem_req_t instr_req,
  input  bus_pkg::mem_req_t data_req,
  output bus_pkg::mem_rsp_t instr_rsp,
  output bus_pkg::mem_rsp_t data_rsp
);

  bus_pkg::mem_req_t bus_req;
  bus_pkg::mem_rsp_t bus_rsp;

  // AXI4 link between bridge and SRAM
  axi_pkg::axi_aw_t           aw;
  axi_pkg::axi_w_t            w;
  axi_pkg::axi_b_t            b;
  axi_pkg::axi_ar_t           ar;
  axi_pkg::axi_r_t            r;
  axi_pkg::axi_master_ready_t m_ready;
  axi_pkg::axi_slave_ready_t  s_ready;

  mem_arbiter u_arbiter (
    .clk       (clk),
    .rst       (rst),
    .instr_req (instr_req),
    .data_req  (data_req),
    .bus_rsp   (bus_rsp),
    .instr_rsp (instr_rsp),
    .data_rsp  (data_rsp),
    .bus_req   (bus_req)
  );

  axi_master u_master (
    .clk     (clk),
    .rst     (rst),
    .req     (bus_req),
    .b       (b),
    .r       (r),
    .s_ready (s_ready),
    .rsp     (bus_rsp),
    .aw      (aw),
    .w       (w),
    .ar      (ar),
    .m_ready (m_ready)
  );

  axi_sram #(
    .DEPTH (DEPTH)
  ) u_sram (
    .clk     (clk),
    .rst     (rst),
    .aw      (aw),
    .w       (w),
    .ar      (ar),
    .m_ready (m_ready),
    .b       (b),
    .r       (r),
    .s_ready (s_ready)
  );

endmodule

// ==== verification/tb_mem_subsystem.sv ====
`timescale 1ns/1ps

module tb_mem_subsystem;

  localparam int depth = 256;
  localparam int reset_cycles = 16;
  localparam int idle_cycles = 4;
  localparam int n_fill = depth;
  localparam int n_directed = 6;
  localparam int n_random = 200;
  localparam int total_reqs = n_fill + n_directed + 2 * n_random;
  localparam int cycle_limit = 40 * total_reqs + reset_cycles + idle_cycles;

  logic clk = 1'b0;
  logic rst;

  bus_pkg::mem_req_t instr_req;
  bus_pkg::mem_req_t data_req;
  bus_pkg::mem_rsp_t instr_rsp;
  bus_pkg::mem_rsp_t data_rsp;

  integer seed;
  int     errors = 0;
  int     cycles = 0;

  // port 0 is the instruction port and port 1 the data port
  bus_pkg::mem_req_t plan_req [2][1024];
  int                len [2];
  int                pos [2];
  bus_pkg::mem_req_t cur [2];
  logic              busy [2];
  int                gap [2];
  int                waits [2];
  int                issued [2];
  int                completed [2];

  bus_pkg::data_t model [depth];

  mem_subsystem #(
    .DEPTH (depth)
  ) DUT (
    .clk       (clk),
    .rst       (rst),
    .instr_req (instr_req),
    .data_req  (data_req),
    .instr_rsp (instr_rsp),
    .data_rsp  (data_rsp)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles with %0d errors so far", cycles, errors);
      $display("Test failed");
      $finish;
    end
  end

  // **************************************************
  // request building
  // **************************************************

  function automatic string port_name(input int p);
    return (p == 0) ? "instr" : "data";
  endfunction

  function automatic bus_pkg::mem_req_t make_read(input logic instr, input bus_pkg::addr_t a);
    bus_pkg::mem_req_t r;
    r       = '0;
    r.valid = 1'b1;
    r.instr = instr;
    r.addr  = a;
    return r;
  endfunction

  function automatic bus_pkg::mem_req_t make_write(input bus_pkg::addr_t a,
                                                   input bus_pkg::data_t d,
                                                   input bus_pkg::strb_t s);
    bus_pkg::mem_req_t r;
    r       = '0;
    r.valid = 1'b1;
    r.addr  = a;
    r.wdata = d;
    r.wstrb = s;
    return r;
  endfunction

  task automatic add_request(input int p, input bus_pkg::mem_req_t r);
    plan_req[p][len[p]] = r;
    len[p]++;
  endtask

  // **************************************************
  // response checking against the model
  // **************************************************

  task automatic check_response(input int p, input bus_pkg::mem_rsp_t rsp);
    int             idx;
    int             q;
    bus_pkg::data_t expected;
    if (rsp.ready) begin
      completed[p]++;
      if (!busy[p]) begin
        errors++;
        $display("%s port saw ready with no request outstanding", port_name(p));
      end else begin
        // the SRAM wraps the word address inside its depth
        idx = int'((cur[p].addr >> 2) % depth);
        if (cur[p].wstrb != '0) begin
          for (int b = 0; b < 4; b++) begin
            if (cur[p].wstrb[b]) begin
              model[idx][8*b +: 8] = cur[p].wdata[8*b +: 8];
            end
          end
        end else begin
          expected = model[idx];
          if (rsp.rdata !== expected) begin
            errors++;
            $display("mismatch %s_rsp.rdata: got %h expected %h at addr %h",
                     port_name(p), rsp.rdata, expected, cur[p].addr);
          end
        end
        busy[p] = 1'b0;
        cur[p] = '0;
        waits[p] = 0;
        gap[p] = int'({$random(seed)} % 4);
        q = 1 - p;
        if (busy[q]) begin
          waits[q]++;
          if (waits[q] > 1) begin
            errors++;
            $display("%s port waited through two completions of the %s port",
                     port_name(q), port_name(p));
          end
        end
      end
    end
  endtask

  // runs every planned request of both ports to completion
  task automatic run_traffic();
    int p;
    for (p = 0; p < 2; p++) begin
      pos[p] = 0;
      gap[p] = int'({$random(seed)} % 4);
    end
    while (pos[0] < len[0] || pos[1] < len[1] || busy[0] || busy[1]) begin
      @(negedge clk);
      check_response(0, instr_rsp);
      check_response(1, data_rsp);
      @(posedge clk);
      for (p = 0; p < 2; p++) begin
        if (!busy[p] && pos[p] < len[p]) begin
          if (gap[p] == 0) begin
            cur[p] = plan_req[p][pos[p]];
            pos[p]++;
            busy[p] = 1'b1;
            waits[p] = 0;
            issued[p]++;
          end else begin
            gap[p]--;
          end
        end
      end
      instr_req <= cur[0];
      data_req  <= cur[1];
    end
    len[0] = 0;
    len[1] = 0;
  endtask

  // **************************************************
  // test sequence
  // **************************************************

  initial begin
    int base;
    int word;
    seed = 32'h106e;
    rst = 1'b0;
    instr_req = '0;
    data_req = '0;
    for (int p = 0; p < 2; p++) begin
      len[p] = 0;
      cur[p] = '0;
      busy[p] = 1'b0;
      waits[p] = 0;
      issued[p] = 0;
      completed[p] = 0;
    end

    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b1;

    repeat (idle_cycles) begin
      @(negedge clk);
      if (instr_rsp.ready !== 1'b0) begin
        errors++;
        $display("mismatch instr_rsp.ready: got %h expected 0", instr_rsp.ready);
      end
      if (data_rsp.ready !== 1'b0) begin
        errors++;
        $display("mismatch data_rsp.ready: got %h expected 0", data_rsp.ready);
      end
    end

    // the SRAM powers up unknown, so every word gets a full write first
    for (int i = 0; i < n_fill; i++) begin
      add_request(1, make_write(bus_pkg::addr_t'(i * 4), bus_pkg::data_t'($random(seed)), 4'hf));
    end
    run_traffic();

    // partial strobes merge into the word and a write above the depth reads back low
    add_request(1, make_write(32'h0000_0040, 32'h1122_3344, 4'hf));
    add_request(1, make_write(32'h0000_0040, 32'haabb_ccdd, 4'b0101));
    add_request(1, make_read(1'b0, 32'h0000_0040));
    add_request(1, make_write(32'h0000_0414, 32'h5a5a_0f0f, 4'hf));
    add_request(1, make_read(1'b0, 32'h0000_0014));
    add_request(1, make_read(1'b0, 32'h0000_0c14));
    run_traffic();

    base = int'({$random(seed)} % 240);
    for (int i = 0; i < n_random; i++) begin
      word = base + int'({$random(seed)} % 16) + 256 * int'({$random(seed)} % 4);
      add_request(0, make_read(1'b1, bus_pkg::addr_t'(word * 4)));
      word = base + int'({$random(seed)} % 16) + 256 * int'({$random(seed)} % 4);
      if (({$random(seed)} % 2) == 0) begin
        add_request(1, make_read(1'b0, bus_pkg::addr_t'(word * 4)));
      end else begin
        add_request(1, make_write(bus_pkg::addr_t'(word * 4), bus_pkg::data_t'($random(seed)),
                                  bus_pkg::strb_t'({$random(seed)} % 15 + 1)));
      end
    end
    run_traffic();

    for (int p = 0; p < 2; p++) begin
      if (issued[p] != completed[p]) begin
        errors++;
        $display("%s port issued %0d requests but saw %0d readies",
                 port_name(p), issued[p], completed[p]);
      end
    end

    $display("%0d errors over %0d requests", errors, issued[0] + issued[1]);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
hw/bus_pkg.sv
hw/axi_pkg.sv
hw/mem_arbiter.sv
hw/axi_master.sv
hw/axi_sram.sv
hw/mem_subsystem.sv
verification/tb_mem_subsystem.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f sources.f \
  --top-module tb_mem_subsystem \
  -o sim_mem_subsystem

./obj_dir/sim_mem_subsystem | tee sim.log

if grep -qx "Test passed" sim.log; then
  echo "simulation PASS"
  exit 0
else
  echo "simulation FAIL"
  exit 1
fi
